//--- Makefile
# Verilator build for the moving average filter

VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= sma_filter_tb
RTL_TOP    ?= sma_filter
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
PASS_MSG   ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/sma_hist_if.sv
`timescale 1ns/1ps

interface sma_hist_if;

	logic             wr_en;     // Retiring sample goes to its slot
	sma_pkg::addr_t   wr_addr;
	sma_pkg::sample_t wr_data;
	sma_pkg::addr_t   rd_addr;   // Slot of the sample entering stage 1
	sma_pkg::sample_t rd_data;   // Registered, one edge after rd_addr

	modport core (
		output wr_en,
		output wr_addr,
		output wr_data,
		output rd_addr,
		input  rd_data
	);

	modport mem (
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_addr,
		output rd_data
	);

endinterface

//--- common/sma_pkg.sv
package sma_pkg;

	// Sample and window limits
	localparam int DATA_W   = 32;
	localparam int SEL_W    = 4;
	localparam int MAX_LOG2 = 8;                 // Largest window is 2**8 samples

	// History storage
	localparam int DEPTH    = 1 << MAX_LOG2;
	localparam int ADDR_W   = $clog2(DEPTH);

	// Sum of DEPTH samples needs MAX_LOG2 guard bits
	localparam int SUM_W    = DATA_W + MAX_LOG2;

	typedef logic signed [DATA_W-1:0] sample_t;  // One input sample
	typedef logic signed [SUM_W-1:0]  sum_t;     // Running window sum
	typedef logic        [ADDR_W-1:0] addr_t;    // History slot index
	typedef logic        [SEL_W-1:0]  log2_t;    // Window exponent

endpackage

//--- design/sma_filter.sv
`timescale 1ns/1ps

module sma_filter (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_update_strobe,
	input  logic [sma_pkg::SEL_W-1:0] i_window_sel,
	input  sma_pkg::sample_t          i_data,
	output sma_pkg::sample_t          o_data,
	output logic                      o_valid
);

	sma_pkg::log2_t window_log2;
	logic           window_clear;   // One cycle after a window change

	sma_hist_if hist_if ();

	window_ctrl window_ctrl_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_window_sel (i_window_sel),
		.o_log2       (window_log2),
		.o_clear      (window_clear)
	);

	sma_datapath sma_datapath_inst (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_update_strobe (i_update_strobe),
		.i_data          (i_data),
		.i_log2          (window_log2),
		.i_clear         (window_clear),
		.hist            (hist_if.core),
		.o_data          (o_data),
		.o_valid         (o_valid)
	);

	history_ram history_ram_inst (
		.i_clk (i_clk),
		.hist  (hist_if.mem)
	);

endmodule

//--- design/window_ctrl.sv
`timescale 1ns/1ps

module window_ctrl (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic [sma_pkg::SEL_W-1:0] i_window_sel,
	output sma_pkg::log2_t            o_log2,
	output logic                      o_clear
);

	logic [sma_pkg::SEL_W-1:0] sel_q;
	sma_pkg::log2_t            sel_clamped;
	logic                      sel_change;

	// Input select is sampled every edge
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sel_q <= '0;
		end else begin
			sel_q <= i_window_sel;
		end
	end

	always_comb begin
		if (sel_q > sma_pkg::MAX_LOG2) begin
			sel_clamped = sma_pkg::log2_t'(sma_pkg::MAX_LOG2);  // 9..15 act as 8
		end else begin
			sel_clamped = sel_q;
		end
	end

	assign sel_change = (sel_clamped != o_log2);

	// Apply the new exponent and flag the datapath to restart its history
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_log2  <= '0;       // Window of one
			o_clear <= 1'b0;
		end else begin
			o_clear <= sel_change;
			if (sel_change) begin
				o_log2 <= sel_clamped;
			end
		end
	end

endmodule

//--- project.f
common/sma_pkg.sv
common/sma_hist_if.sv
design/window_ctrl.sv
sma_core/history_ram.sv
sma_core/sma_datapath.sv
design/sma_filter.sv
tests/sma_filter_tb.sv

//--- sma_core/history_ram.sv
`timescale 1ns/1ps

module history_ram (
	input  logic   i_clk,
	sma_hist_if.mem hist
);

	sma_pkg::sample_t mem [sma_pkg::DEPTH];

	// Write port
	always_ff @(posedge i_clk) begin
		if (hist.wr_en) begin
			mem[hist.wr_addr] <= hist.wr_data;
		end
	end

	// Read port, registered on every edge.
	// A read of the slot being written returns the previous contents.
	always_ff @(posedge i_clk) begin
		hist.rd_data <= mem[hist.rd_addr];
	end

endmodule

//--- sma_core/sma_datapath.sv
`timescale 1ns/1ps

module sma_datapath (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_update_strobe,
	input  sma_pkg::sample_t i_data,
	input  sma_pkg::log2_t   i_log2,
	input  logic             i_clear,
	sma_hist_if.core         hist,
	output sma_pkg::sample_t o_data,
	output logic             o_valid
);

	// Window geometry
	logic [sma_pkg::ADDR_W:0] win_len;       // N, up to DEPTH
	sma_pkg::addr_t           slot_mask;     // N - 1

	// History bookkeeping
	sma_pkg::addr_t           wr_ptr;
	logic [sma_pkg::ADDR_W:0] fill_cnt;      // Slots written since clear, saturates at N
	logic                     slot_full;
	logic                     accept;
	logic                     fwd_hit;

	// Stage 1
	logic                     s1_valid;
	sma_pkg::sample_t         s1_data;
	sma_pkg::addr_t           s1_addr;
	logic                     s1_full;       // Old sample leaves the window
	logic                     s1_fwd;        // Old sample comes from the bypass
	sma_pkg::sample_t         s1_fwd_data;

	// Stage 2
	logic                     retire;
	sma_pkg::sample_t         old_sample;
	sma_pkg::sum_t            sum_q;
	sma_pkg::sum_t            sum_next;

	assign win_len   = {{sma_pkg::ADDR_W{1'b0}}, 1'b1} << i_log2;
	assign slot_mask = sma_pkg::addr_t'(win_len - 1'b1);
	assign slot_full = (fill_cnt == win_len);

	// A strobe in the clear cycle is dropped
	assign accept = i_update_strobe & ~i_clear;
	assign retire = s1_valid & ~i_clear;

	// RAM link
	assign hist.rd_addr = wr_ptr;
	assign hist.wr_en   = retire;
	assign hist.wr_addr = s1_addr;
	assign hist.wr_data = s1_data;

	// Slot read now is being written now, RAM would return stale data
	assign fwd_hit = hist.wr_en && (hist.wr_addr == wr_ptr);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr   <= '0;
			fill_cnt <= '0;
		end else if (i_clear) begin
			wr_ptr   <= '0;
			fill_cnt <= '0;
		end else if (accept) begin
			wr_ptr <= (wr_ptr + 1'b1) & slot_mask;  // Wrap at N
			if (!slot_full) begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= accept;                      // Clear also empties stage 1
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			s1_data     <= i_data;
			s1_addr     <= wr_ptr;
			s1_full     <= slot_full;
			s1_fwd      <= fwd_hit;
			s1_fwd_data <= hist.wr_data;
		end
	end

	assign old_sample = s1_fwd ? s1_fwd_data : hist.rd_data;

	always_comb begin
		sum_next = sum_q + sma_pkg::sum_t'(s1_data);
		if (s1_full) begin
			sum_next = sum_next - sma_pkg::sum_t'(old_sample);
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum_q <= '0;
		end else if (i_clear) begin
			sum_q <= '0;
		end else if (retire) begin
			sum_q <= sum_next;
		end
	end

	// Floor of the mean, low bits are exact
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end else begin
			o_valid <= retire;
			if (retire) begin
				o_data <= sma_pkg::sample_t'(sum_next >>> i_log2);
			end
		end
	end

endmodule

//--- tests/sma_filter_tb.sv
`timescale 1ns/1ps

module sma_filter_tb;

	localparam int unsigned SEED           = 32'hebff_2605;
	localparam int          CLK_HALF       = 50;
	localparam int          DRIVE_DLY      = 5;    // After the rising edge
	localparam int          RESULT_TIMEOUT = 20;   // Cycles
	localparam int          IDLE_AFTER_SEL = 4;

	// Sample mixes
	localparam int KIND_ANY     = 0;
	localparam int KIND_NEG     = 1;
	localparam int KIND_EXTREME = 2;
	localparam int KIND_MIN     = 3;

	logic                      i_clk;
	logic                      i_rst_n;
	logic                      i_update_strobe;
	logic [sma_pkg::SEL_W-1:0] i_window_sel;
	sma_pkg::sample_t          i_data;
	sma_pkg::sample_t          o_data;
	logic                      o_valid;

	sma_pkg::sample_t          win_q[$];     // Up to N samples since the last window change
	sma_pkg::log2_t            cur_log2;
	sma_pkg::sample_t          exp_q[$];
	int                        due_q[$];     // Cycle in which each result must show
	int                        cycle;
	bit                        monitor_on;
	logic [sma_pkg::SEL_W-1:0] next_sel;
	sma_pkg::sample_t          head_value;
	int                        head_due;

	sma_filter sma_filter_inst (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_update_strobe (i_update_strobe),
		.i_window_sel    (i_window_sel),
		.i_data          (i_data),
		.o_data          (o_data),
		.o_valid         (o_valid)
	);

	always #CLK_HALF i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_average(input sma_pkg::sample_t expected,
			input sma_pkg::sample_t actual);
		if (actual !== expected) begin
			$display("FAIL o_data expected %h actual %h", expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_idle(input logic actual_valid, input sma_pkg::sample_t actual_data,
			input bit data_zero);
		if (actual_valid !== 1'b0) begin
			$display("FAIL o_valid expected %h actual %h", 1'b0, actual_valid);
			stop_with_failure();
		end else if (data_zero && actual_data !== '0) begin
			$display("FAIL o_data expected %h actual %h", sma_pkg::sample_t'(0), actual_data);
			stop_with_failure();
		end
	endtask

	// Select values above the largest window act as the largest window
	function automatic sma_pkg::log2_t effective_log2(input logic [sma_pkg::SEL_W-1:0] sel);
		if (sel > 4'd8) begin
			return 4'd8;
		end
		return sel;
	endfunction

	// Floor of the mean over the full N with empty slots as zero
	function automatic sma_pkg::sample_t expected_average();
		sma_pkg::sum_t total;
		total = '0;
		foreach (win_q[i]) begin
			total = total + sma_pkg::sum_t'(win_q[i]);
		end
		return sma_pkg::sample_t'(total >>> cur_log2);
	endfunction

	function automatic sma_pkg::sample_t random_sample(input int kind);
		sma_pkg::sample_t s;
		case (kind)
			KIND_NEG: s = sma_pkg::sample_t'({1'b1, 31'($urandom())});
			KIND_EXTREME: begin
				case ($urandom_range(0, 4))
					0: s = sma_pkg::sample_t'(32'h8000_0000);
					1: s = sma_pkg::sample_t'(32'h7fff_ffff);
					2: s = -1;
					3: s = 1;
					default: s = sma_pkg::sample_t'($urandom());
				endcase
			end
			KIND_MIN: s = sma_pkg::sample_t'(32'h8000_0000);
			default: s = sma_pkg::sample_t'($urandom());
		endcase
		return s;
	endfunction

	task automatic idle_cycle();
		@(posedge i_clk);
		#DRIVE_DLY;
		i_update_strobe = 1'b0;
		i_data          = sma_pkg::sample_t'($urandom());
	endtask

	task automatic strobe_cycle(input sma_pkg::sample_t sample);
		@(posedge i_clk);
		#DRIVE_DLY;
		i_update_strobe = 1'b1;
		i_data          = sample;
		win_q.push_back(sample);
		while (win_q.size() > (1 << cur_log2)) begin
			void'(win_q.pop_front());
		end
		exp_q.push_back(expected_average());
		due_q.push_back(cycle + 2);          // Two edges after the drive
	endtask

	task automatic run_strobes(input int count, input int kind, input int gap_max);
		for (int i = 0; i < count; i++) begin
			if (gap_max > 0 && $urandom_range(0, 2) == 0) begin
				repeat ($urandom_range(1, gap_max)) begin
					idle_cycle();
				end
			end
			strobe_cycle(random_sample(kind));
		end
	endtask

	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < RESULT_TIMEOUT) begin
			idle_cycle();
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("No result arrived on o_valid within %0d cycles", RESULT_TIMEOUT);
			stop_with_failure();
		end
	endtask

	task automatic set_window(input logic [sma_pkg::SEL_W-1:0] sel);
		sma_pkg::log2_t new_log2;
		wait_results();
		idle_cycle();
		i_window_sel = sel;
		new_log2     = effective_log2(sel);
		if (new_log2 != cur_log2) begin
			cur_log2 = new_log2;   // DUT restarts its history
			win_q.delete();
		end
		repeat (IDLE_AFTER_SEL) begin
			idle_cycle();
		end
	endtask

	// Results are sampled in the middle of the cycle
	always @(negedge i_clk) begin
		if (monitor_on) begin
			if (o_valid === 1'b1 && exp_q.size() != 0) begin
				head_value = exp_q.pop_front();
				head_due   = due_q.pop_front();
				if (head_due != cycle) begin
					$display("Result came in cycle %0d but was due in cycle %0d", cycle, head_due);
					stop_with_failure();
				end else begin
					check_average(head_value, o_data);
				end
			end else if (o_valid !== 1'b1 && exp_q.size() != 0 && cycle > due_q[0]) begin
				$display("No result arrived for the strobe due in cycle %0d", due_q[0]);
				stop_with_failure();
			end else begin
				check_idle(o_valid, o_data, 1'b0);
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		i_clk           = 1'b0;
		i_rst_n         = 1'b0;
		i_update_strobe = 1'b0;
		i_window_sel    = '0;
		i_data          = '0;
		cur_log2        = '0;
		repeat (2) @(posedge i_clk);
		#DRIVE_DLY;
		i_rst_n    = 1'b1;
		monitor_on = 1'b1;

		repeat (4) begin
			@(negedge i_clk);
			check_idle(o_valid, o_data, 1'b1);
		end

		// Back-to-back strobes with a window of one exercise the RAM bypass
		run_strobes(40, KIND_ANY, 0);
		run_strobes(20, KIND_EXTREME, 0);

		// Random windows that each start from a partial history
		repeat (10) begin
			next_sel = 4'($urandom_range(0, 8));
			set_window(next_sel);
			run_strobes((1 << cur_log2) + int'($urandom_range(4, 40)), KIND_ANY, 3);
		end

		set_window(4'd12);
		run_strobes(300, KIND_ANY, 2);
		set_window(4'd15);      // Same effective window so no clear
		run_strobes(60, KIND_ANY, 2);
		repeat (3) begin
			next_sel = 4'($urandom_range(9, 15));
			set_window(next_sel);
			run_strobes(40, KIND_ANY, 1);
		end

		// Signed rounding
		set_window(4'd2);
		run_strobes(30, KIND_NEG, 1);
		set_window(4'd5);
		run_strobes(80, KIND_EXTREME, 1);
		set_window(4'd8);
		run_strobes(270, KIND_MIN, 0);
		run_strobes(270, KIND_EXTREME, 0);
		set_window(4'd0);
		run_strobes(20, KIND_EXTREME, 0);

		wait_results();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
